//--- compile.f
hw/ru_pkg.sv
hw/ru_cmd_if.sv
hw/ru_wd_if.sv
hw/ru_cmd_decoder.sv
hw/ru_param_store.sv
hw/ru_reconfig_monitor.sv
hw/cyclone_ru_ctrl.sv
verif/tb_clock_gen.sv
verif/tb_cyclone_ru.sv

//--- hw/cyclone_ru_ctrl.sv
// remote-update control top, decoder, parameter store and monitor
`timescale 1ns/10ps

module cyclone_ru_ctrl import ru_pkg::*; #(
	parameter int BUSY_CYCLES = 4
) (
	input  logic                  clock_rd2,
	input  logic                  reset_n,
	// control word and parameter access
	input  logic [RU_CTRL_W-1:0]  ru_ctrl,
	input  logic [RU_PARAM_W-1:0] ru_param,
	input  logic [RU_DATA_W-1:0]  ru_data_in,
	output logic [RU_DATA_W-1:0]  ru_data_out,
	// falls at the end of each read or write
	output logic                  ru_busy
);

	// ==================================================
	// internal links
	// ==================================================
	ru_cmd_if cmd ();
	ru_wd_if wd ();

	// ru_ctrl sampling, pulses and levels
	ru_cmd_decoder u_decoder (
		.clock_rd2  (clock_rd2),
		.reset_n    (reset_n),
		.ru_ctrl    (ru_ctrl),
		.ru_param   (ru_param),
		.ru_data_in (ru_data_in),
		.cmd        (cmd)
	);

	// parameter registers and busy window
	ru_param_store #(
		.BUSY_CYCLES (BUSY_CYCLES)
	) u_store (
		.clock_rd2   (clock_rd2),
		.reset_n     (reset_n),
		.cmd         (cmd),
		.wd          (wd),
		.ru_data_out (ru_data_out),
		.ru_busy     (ru_busy)
	);

	// watchdog and reconfiguration cause
	ru_reconfig_monitor u_monitor (
		.clock_rd2 (clock_rd2),
		.reset_n   (reset_n),
		.cmd       (cmd),
		.wd        (wd)
	);

endmodule

//--- hw/ru_cmd_decoder.sv
// control word sampler and opcode decoder
`timescale 1ns/10ps

module ru_cmd_decoder import ru_pkg::*; (
	input  logic                  clock_rd2,
	input  logic                  reset_n,
	input  logic [RU_CTRL_W-1:0]  ru_ctrl,
	input  logic [RU_PARAM_W-1:0] ru_param,
	input  logic [RU_DATA_W-1:0]  ru_data_in,
	ru_cmd_if.decoder             cmd
);

	// two sampled copies of the control word
	logic [RU_CTRL_W-1:0] ctrl_q;
	logic [RU_CTRL_W-1:0] ctrl_last;
	ru_op_t               op_q;
	ru_op_t               op_last;
	logic                 last_idle;

	assign op_q = ru_op_t'(ctrl_q);
	assign op_last = ru_op_t'(ctrl_last);

	// previous word counts as idle unless it is a known opcode
	assign last_idle = !(op_last inside {OP_READ, OP_WRITE, OP_RESET, OP_RECONFIG});

	// ==================================================
	// sampling and command registers
	// ==================================================
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			ctrl_q <= '0;
			ctrl_last <= '0;
			cmd.read_param <= 1'b0;
			cmd.write_param <= 1'b0;
			cmd.ru_reset <= 1'b0;
			cmd.reconfig <= 1'b0;
		end else begin
			ctrl_q <= ru_ctrl;
			ctrl_last <= ctrl_q;
			// read/write fire once, on the move out of idle
			cmd.read_param <= (op_q == OP_READ) && last_idle;
			cmd.write_param <= (op_q == OP_WRITE) && last_idle;
			// reset and reconfig follow the word as levels
			cmd.ru_reset <= (op_q == OP_RESET);
			cmd.reconfig <= (op_q == OP_RECONFIG);
		end
	end

	// index and data, registered in step with the pulses
	always_ff @(posedge clock_rd2) begin
		cmd.param <= ru_param;
		cmd.data_in <= ru_data_in;
	end

endmodule

//--- hw/ru_cmd_if.sv
// decoded remote-update command bundle, decoder to store and monitor
`timescale 1ns/10ps

interface ru_cmd_if import ru_pkg::*; ();

	// one-cycle pulses, param and data_in valid alongside
	logic                  read_param;
	logic                  write_param;
	// levels, held while the opcode persists
	logic                  ru_reset;
	logic                  reconfig;
	// sampled index and write data
	logic [RU_PARAM_W-1:0] param;
	logic [RU_DATA_W-1:0]  data_in;

	modport decoder (
		output read_param, write_param, ru_reset, reconfig, param, data_in
	);

	modport store (
		input read_param, write_param, ru_reset, reconfig, param, data_in
	);

	// monitor only watches for the reconfig edge
	modport monitor (
		input reconfig
	);

endinterface

//--- hw/ru_param_store.sv
// remote-update parameter registers with busy window,
// field masking and reload to defaults
`timescale 1ns/10ps

module ru_param_store import ru_pkg::*; #(
	parameter int BUSY_CYCLES = 4
) (
	input  logic                 clock_rd2,
	input  logic                 reset_n,
	ru_cmd_if.store              cmd,
	ru_wd_if.store               wd,
	output logic [RU_DATA_W-1:0] ru_data_out,
	output logic                 ru_busy
);

	localparam int CNT_W = $clog2(BUSY_CYCLES + 1);

	// parameter registers
	logic [WD_TIMEOUT_W-1:0] wd_timeout_r;
	logic                    wd_enable_r;
	logic [RU_DATA_W-1:0]    boot_addr_r;

	// busy window and pending operation
	logic [CNT_W-1:0]        busy_cnt;
	logic                    pend_write;
	ru_param_t               pend_param;
	logic [RU_DATA_W-1:0]    pend_data;
	logic                    accept;
	logic                    restore;
	logic [RU_DATA_W-1:0]    rd_value;

	// pulses seen during busy are dropped
	assign accept = !ru_busy && (cmd.read_param || cmd.write_param);
	// remote-update reset or monitor reload
	assign restore = cmd.ru_reset || wd.reload;

	assign wd.wd_timeout = wd_timeout_r;
	assign wd.wd_enable = wd_enable_r;

	// read mux, cause sampled at completion
	always_comb begin
		case (pend_param)
			PARAM_CAUSE:      rd_value = RU_DATA_W'(wd.cause);
			PARAM_WD_TIMEOUT: rd_value = RU_DATA_W'(wd_timeout_r);
			PARAM_WD_ENABLE:  rd_value = RU_DATA_W'(wd_enable_r);
			PARAM_BOOT_ADDR:  rd_value = boot_addr_r;
			default:          rd_value = '0;
		endcase
	end

	// ==================================================
	// busy sequencing and register update
	// ==================================================
	always_ff @(posedge clock_rd2) begin
		if (!reset_n || restore) begin
			// abort, back to defaults
			ru_busy <= 1'b0;
			busy_cnt <= '0;
			pend_write <= 1'b0;
			wd_timeout_r <= '0;
			wd_enable_r <= 1'b0;
			boot_addr_r <= '0;
			ru_data_out <= '0;
		end else if (ru_busy) begin
			if (busy_cnt == '0) begin
				// end of window, busy drops here
				ru_busy <= 1'b0;
				if (pend_write) begin
					// masked to field width, cause is read-only
					case (pend_param)
						PARAM_WD_TIMEOUT: wd_timeout_r <= pend_data[WD_TIMEOUT_W-1:0];
						PARAM_WD_ENABLE:  wd_enable_r <= pend_data[0];
						PARAM_BOOT_ADDR:  boot_addr_r <= pend_data;
						default:          ;
					endcase
				end else begin
					ru_data_out <= rd_value;
				end
			end else begin
				busy_cnt <= busy_cnt - 1'b1;
			end
		end else if (accept) begin
			// first busy cycle counts, hence the minus one
			ru_busy <= 1'b1;
			busy_cnt <= CNT_W'(BUSY_CYCLES - 1);
			pend_write <= cmd.write_param;
		end
	end

	// latched index and data of the accepted operation
	always_ff @(posedge clock_rd2) begin
		if (accept) begin
			pend_param <= ru_param_t'(cmd.param);
			pend_data <= cmd.data_in;
		end
	end

endmodule

//--- hw/ru_pkg.sv
// remote-update shared widths, control opcodes, parameter indices
// and reconfiguration cause codes
package ru_pkg;

	// ==================================================
	// bus and field widths
	// ==================================================
	localparam int RU_DATA_W = 32;
	localparam int RU_PARAM_W = 3;
	localparam int RU_CTRL_W = 3;
	// watchdog timeout field
	localparam int WD_TIMEOUT_W = 12;
	// free-running kick counter, msb is the kick level
	localparam int KICK_CNT_W = 8;

	// ==================================================
	// control word opcodes on ru_ctrl
	// ==================================================
	// codes not listed decode as idle
	typedef enum logic [RU_CTRL_W-1:0] {
		OP_IDLE     = 3'b000,
		OP_READ     = 3'b001,
		OP_WRITE    = 3'b010,
		OP_RESET    = 3'b100,
		OP_RECONFIG = 3'b111
	} ru_op_t;

	// parameter indices, 1/5/6/7 unmapped
	typedef enum logic [RU_PARAM_W-1:0] {
		PARAM_CAUSE      = 3'd0,
		PARAM_WD_TIMEOUT = 3'd2,
		PARAM_WD_ENABLE  = 3'd3,
		PARAM_BOOT_ADDR  = 3'd4
	} ru_param_t;

	// why the last reconfiguration happened
	typedef enum logic [1:0] {
		CAUSE_POWER_ON = 2'd0,
		CAUSE_RECONFIG = 2'd1,
		CAUSE_WATCHDOG = 2'd2
	} ru_cause_t;

endpackage

//--- hw/ru_reconfig_monitor.sv
// watchdog kick counter, timeout counter and reconfiguration cause
`timescale 1ns/10ps

module ru_reconfig_monitor import ru_pkg::*; (
	input  logic       clock_rd2,
	input  logic       reset_n,
	ru_cmd_if.monitor  cmd,
	ru_wd_if.monitor   wd
);

	// free-running kick counter
	logic [KICK_CNT_W-1:0]   kick_cnt;
	logic                    kick;
	logic                    kick_q;
	logic                    kick_rise;
	// watchdog timeout counter
	logic [WD_TIMEOUT_W-1:0] to_cnt;
	logic                    wd_expire;
	// reconfig edge detect
	logic                    reconfig_q;
	logic                    reconfig_rise;

	// msb of the counter is the kick level
	assign kick = kick_cnt[KICK_CNT_W-1];
	assign kick_rise = kick && !kick_q;
	assign reconfig_rise = cmd.reconfig && !reconfig_q;

	// a zero timeout never expires
	assign wd_expire = wd.wd_enable && (wd.wd_timeout != '0) && (to_cnt == wd.wd_timeout);

	// ==================================================
	// counters, reload pulse and cause
	// ==================================================
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			kick_cnt <= '0;
			kick_q <= 1'b0;
			to_cnt <= '0;
			reconfig_q <= 1'b0;
			wd.reload <= 1'b0;
			wd.cause <= CAUSE_POWER_ON;
		end else begin
			kick_cnt <= kick_cnt + 1'b1;
			kick_q <= kick;
			reconfig_q <= cmd.reconfig;
			// one cycle, store clears enable on it
			wd.reload <= reconfig_rise || wd_expire;
			// timeout counts only between kicks while enabled
			if (!wd.wd_enable || kick_rise || wd_expire) begin
				to_cnt <= '0;
			end else begin
				to_cnt <= to_cnt + 1'b1;
			end
			// cause survives ru_reset and reload
			if (reconfig_rise) begin
				wd.cause <= CAUSE_RECONFIG;
			end else if (wd_expire) begin
				wd.cause <= CAUSE_WATCHDOG;
			end
		end
	end

endmodule

//--- hw/ru_wd_if.sv
// watchdog settings and reload/cause link, store to monitor
`timescale 1ns/10ps

interface ru_wd_if import ru_pkg::*; ();

	// watchdog settings from the store registers
	logic [WD_TIMEOUT_W-1:0] wd_timeout;
	logic                    wd_enable;
	// one-cycle pulse, restores store defaults
	logic                    reload;
	// last reconfiguration cause
	ru_cause_t               cause;

	modport store (
		output wd_timeout, wd_enable,
		input  reload, cause
	);

	modport monitor (
		input  wd_timeout, wd_enable,
		output reload, cause
	);

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the remote-update testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_cyclone_ru \
	-f compile.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "test passed" sim.log; then
	echo "simulation: PASS"
else
	echo "simulation: FAIL"
	exit 1
fi

//--- verif/tb_clock_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clock_rd2,
	output logic reset_n
);

	initial begin
		clock_rd2 = 1'b0;
		forever #(PERIOD_NS / 2) clock_rd2 = ~clock_rd2;
	end

	// low over RESET_CYCLES rising edges, released on a falling edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_rd2);
		@(negedge clock_rd2);
		reset_n = 1'b1;
	end

endmodule

//--- verif/tb_cyclone_ru.sv
// table-driven testbench for the remote-update control path,
// lcg write data, busy handshakes, reset/reconfig and watchdog
`timescale 1ns/10ps

module tb_cyclone_ru import ru_pkg::*; ();

	// default busy window of the DUT
	localparam int BUSY_CYCLES = 4;

	typedef struct packed {
		logic [2:0]  op;
		logic [2:0]  param;
		logic [31:0] data;
		logic [31:0] exp_val;
	} step_t;

	wire         clock_rd2;
	wire         reset_n;
	logic [2:0]  ru_ctrl;
	logic [2:0]  ru_param;
	logic [31:0] ru_data_in;
	logic [31:0] ru_data_out;
	logic        ru_busy;

	step_t       steps[$];
	logic [31:0] lcg_state = 32'd43;

	tb_clock_gen u_clock_gen (
		.clock_rd2 (clock_rd2),
		.reset_n   (reset_n)
	);

	cyclone_ru_ctrl UUT (
		.clock_rd2   (clock_rd2),
		.reset_n     (reset_n),
		.ru_ctrl     (ru_ctrl),
		.ru_param    (ru_param),
		.ru_data_in  (ru_data_in),
		.ru_data_out (ru_data_out),
		.ru_busy     (ru_busy)
	);

	// ==================================================
	// helpers
	// ==================================================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic void add_step(logic [2:0] op, logic [2:0] param,
		logic [31:0] data, logic [31:0] exp_val);
		steps.push_back('{op, param, data, exp_val});
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		$display("test failed");
		$fatal(1, "wait timed out");
	endtask

	// sampled on falling edges where outputs are settled
	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (ru_busy !== level) begin
			@(negedge clock_rd2);
			n++;
			if (n > 40) report_timeout(what);
		end
	endtask

	// one read or write that returns to idle once busy drops
	task automatic run_op(input logic [2:0] op, input logic [2:0] param,
		input logic [31:0] data);
		@(negedge clock_rd2);
		ru_ctrl = op;
		ru_param = param;
		ru_data_in = data;
		wait_busy(1'b1, "ru_busy never rose after a command");
		wait_busy(1'b0, "ru_busy never fell after a command");
		ru_ctrl = OP_IDLE;
	endtask

	// reset and reconfig levels held for 4 cycles
	task automatic hold_level(input logic [2:0] op);
		@(negedge clock_rd2);
		ru_ctrl = op;
		repeat (4) @(negedge clock_rd2);
		ru_ctrl = OP_IDLE;
	endtask

	// ==================================================
	// stimulus table and checks
	// ==================================================
	initial begin
		step_t       s;
		logic [31:0] d_to;
		logic [31:0] d_en;
		logic [31:0] d_ba;
		int          busy_len;
		int          n;

		ru_ctrl = OP_IDLE;
		ru_param = '0;
		ru_data_in = '0;

		// power-on cause first
		add_step(OP_READ, PARAM_CAUSE, 32'd0, 32'd0);
		for (int r = 0; r < 2; r++) begin
			// bit 10 set keeps the timeout above 1000
			d_to = lcg_next() | 32'h400;
			d_en = lcg_next();
			d_ba = lcg_next();
			add_step(OP_WRITE, PARAM_WD_TIMEOUT, d_to, 32'd0);
			add_step(OP_WRITE, PARAM_WD_ENABLE, d_en, 32'd0);
			add_step(OP_WRITE, PARAM_BOOT_ADDR, d_ba, 32'd0);
			add_step(OP_READ, PARAM_WD_TIMEOUT, 32'd0, d_to & 32'hfff);
			add_step(OP_READ, PARAM_WD_ENABLE, 32'd0, d_en & 32'h1);
			add_step(OP_READ, PARAM_BOOT_ADDR, 32'd0, d_ba);
		end
		// unmapped indices
		add_step(OP_READ, 3'd1, 32'd0, 32'd0);
		add_step(OP_READ, 3'd5, 32'd0, 32'd0);
		add_step(OP_READ, 3'd6, 32'd0, 32'd0);
		add_step(OP_READ, 3'd7, 32'd0, 32'd0);
		// cause is read-only, low bits set so a stray write would show
		add_step(OP_WRITE, PARAM_CAUSE, lcg_next() | 32'h1, 32'd0);
		add_step(OP_READ, PARAM_CAUSE, 32'd0, 32'd0);
		// enable set so the reset has something to clear
		add_step(OP_WRITE, PARAM_WD_ENABLE, 32'd1, 32'd0);
		// nonzero data out before the reset
		add_step(OP_READ, PARAM_BOOT_ADDR, 32'd0, d_ba);
		add_step(OP_RESET, 3'd0, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_WD_TIMEOUT, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_WD_ENABLE, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_BOOT_ADDR, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_CAUSE, 32'd0, 32'd0);
		// timeout stays 0 with enable set
		d_ba = lcg_next() | 32'h1;
		add_step(OP_WRITE, PARAM_BOOT_ADDR, d_ba, 32'd0);
		add_step(OP_WRITE, PARAM_WD_ENABLE, 32'd1, 32'd0);
		add_step(OP_READ, PARAM_BOOT_ADDR, 32'd0, d_ba);
		add_step(OP_RECONFIG, 3'd0, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_CAUSE, 32'd0, 32'd1);
		add_step(OP_READ, PARAM_WD_ENABLE, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_BOOT_ADDR, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_WD_TIMEOUT, 32'd0, 32'd0);
		// reconfig cause survives a later reset
		add_step(OP_READ, PARAM_CAUSE, 32'd0, 32'd1);
		add_step(OP_RESET, 3'd0, 32'd0, 32'd0);
		add_step(OP_READ, PARAM_CAUSE, 32'd0, 32'd1);

		n = 0;
		while (reset_n !== 1'b1) begin
			@(negedge clock_rd2);
			n++;
			if (n > 10) report_timeout("reset was never released");
		end
		check_value("busy after reset", 32'd0, ru_busy);
		check_value("data out after reset", 32'd0, ru_data_out);

		foreach (steps[i]) begin
			s = steps[i];
			if (s.op == OP_RESET || s.op == OP_RECONFIG) begin
				hold_level(s.op);
				check_value($sformatf("step %0d data out after hold", i), s.exp_val,
					ru_data_out);
			end else begin
				run_op(s.op, s.param, s.data);
				if (s.op == OP_READ)
					check_value($sformatf("step %0d read param %0d", i, s.param),
						s.exp_val, ru_data_out);
			end
		end

		// read arriving mid-window is dropped
		d_ba = lcg_next() | 32'h1;
		run_op(OP_WRITE, PARAM_BOOT_ADDR, d_ba);
		@(negedge clock_rd2);
		ru_ctrl = OP_READ;
		ru_param = PARAM_BOOT_ADDR;
		wait_busy(1'b1, "ru_busy never rose for the first read");
		busy_len = 0;
		while (ru_busy === 1'b1) begin
			busy_len++;
			if (busy_len == 1) ru_ctrl = OP_IDLE;
			if (busy_len == 2) begin
				ru_ctrl = OP_READ;
				ru_param = PARAM_WD_TIMEOUT;
			end
			@(negedge clock_rd2);
			if (busy_len > 40) report_timeout("ru_busy stuck high during the dropped read");
		end
		ru_ctrl = OP_IDLE;
		check_value("busy window with dropped read", BUSY_CYCLES, busy_len);
		check_value("data out keeps first read", d_ba, ru_data_out);
		repeat (8) begin
			@(negedge clock_rd2);
			check_value("no busy from dropped read", 32'd0, ru_busy);
		end

		// short timeout where the watchdog fires once
		run_op(OP_WRITE, PARAM_WD_TIMEOUT, 32'd20);
		run_op(OP_WRITE, PARAM_WD_ENABLE, 32'd1);
		run_op(OP_READ, PARAM_WD_ENABLE, 32'd0);
		check_value("enable before expiry", 32'd1, ru_data_out);
		// reload clears data out and so marks the expiry
		n = 0;
		while (ru_data_out !== 32'd0) begin
			@(negedge clock_rd2);
			n++;
			if (n > 600) report_timeout("watchdog did not expire within 600 cycles");
		end
		run_op(OP_READ, PARAM_CAUSE, 32'd0);
		check_value("cause after watchdog", 32'd2, ru_data_out);
		run_op(OP_READ, PARAM_WD_ENABLE, 32'd0);
		check_value("enable after watchdog", 32'd0, ru_data_out);

		// long timeout stays quiet over 600 cycles
		run_op(OP_WRITE, PARAM_WD_TIMEOUT, 32'd1000);
		run_op(OP_WRITE, PARAM_WD_ENABLE, 32'd1);
		repeat (600) @(negedge clock_rd2);
		run_op(OP_READ, PARAM_CAUSE, 32'd0);
		check_value("cause with long timeout", 32'd2, ru_data_out);
		run_op(OP_READ, PARAM_WD_ENABLE, 32'd0);
		check_value("enable with long timeout", 32'd1, ru_data_out);

		$display("test passed");
		$finish;
	end

endmodule
